//--- files.f
logic/fetch_pkg.sv
logic/pc_counter.sv
logic/fetch_control.sv
logic/fetch_stage.sv
logic/instruction_buffer.sv
logic/fetch_buffer_top.sv
verification/fetch_checker.sv
verification/fetch_buffer_tb.sv

//--- logic/fetch_buffer_top.sv
`timescale 1ns/1ps

module fetch_buffer_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // Three-port instruction memory
    output fetch_pkg::pc_t        inst_addr_0_o,
    output fetch_pkg::pc_t        inst_addr_1_o,
    output fetch_pkg::pc_t        inst_addr_2_o,
    input  fetch_pkg::word_t      instruction_0_i,
    input  fetch_pkg::word_t      instruction_1_i,
    input  fetch_pkg::word_t      instruction_2_i,
    // Pipeline control
    input  logic                  flush_i,
    input  fetch_pkg::pc_t        redirect_pc_i,
    input  logic                  bubble_i,
    // Decode lanes
    input  fetch_pkg::lane_mask_t decode_ready_i,
    output fetch_pkg::lane_mask_t decode_valid_o,
    output fetch_pkg::word_t      instr_0_o,
    output fetch_pkg::word_t      instr_1_o,
    output fetch_pkg::word_t      instr_2_o,
    output fetch_pkg::pc_t        pc_0_o,
    output fetch_pkg::pc_t        pc_1_o,
    output fetch_pkg::pc_t        pc_2_o,
    output fetch_pkg::word_t      imm_0_o,
    output fetch_pkg::word_t      imm_1_o,
    output fetch_pkg::word_t      imm_2_o,
    // Buffer status
    output logic                  buffer_empty_o,
    output logic                  buffer_full_o,
    output fetch_pkg::occ_t       occupancy_o
);

    import fetch_pkg::*;

    logic         issue;
    logic         stage_issue;
    logic         load_pc;
    logic         fetch_ready;
    logic         group_valid;
    pc_t          group_pc;
    fetch_state_t ctrl_state;
    word_t        stage_instr_0, stage_instr_1, stage_instr_2;
    pc_t          stage_pc_0, stage_pc_1, stage_pc_2;
    word_t        stage_imm_0, stage_imm_1, stage_imm_2;

    // Sequential word addresses of the group
    assign inst_addr_0_o = group_pc;
    assign inst_addr_1_o = group_pc + pc_t'(4);
    assign inst_addr_2_o = group_pc + pc_t'(8);

    // Group register ignores issue while redirecting
    assign stage_issue = issue && (ctrl_state != FS_REDIRECT);

    pc_counter pc_counter_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .advance_i (issue),
        .load_i    (load_pc),
        .load_pc_i (redirect_pc_i),
        .pc_o      (group_pc)
    );

    fetch_control fetch_control_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .bubble_i      (bubble_i),
        .fetch_ready_i (fetch_ready),
        .issue_o       (issue),
        .load_pc_o     (load_pc),
        .state_o       (ctrl_state)
    );

    fetch_stage fetch_stage_i (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .issue_i         (stage_issue),
        .flush_i         (flush_i),
        .base_pc_i       (group_pc),
        .instruction_0_i (instruction_0_i),
        .instruction_1_i (instruction_1_i),
        .instruction_2_i (instruction_2_i),
        .group_valid_o   (group_valid),
        .instr_0_o       (stage_instr_0),
        .instr_1_o       (stage_instr_1),
        .instr_2_o       (stage_instr_2),
        .pc_0_o          (stage_pc_0),
        .pc_1_o          (stage_pc_1),
        .pc_2_o          (stage_pc_2),
        .imm_0_o         (stage_imm_0),
        .imm_1_o         (stage_imm_1),
        .imm_2_o         (stage_imm_2)
    );

    // Captured group lands in the buffer one edge later
    instruction_buffer instruction_buffer_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .write_i        (group_valid),
        .instr_0_i      (stage_instr_0),
        .instr_1_i      (stage_instr_1),
        .instr_2_i      (stage_instr_2),
        .pc_0_i         (stage_pc_0),
        .pc_1_i         (stage_pc_1),
        .pc_2_i         (stage_pc_2),
        .imm_0_i        (stage_imm_0),
        .imm_1_i        (stage_imm_1),
        .imm_2_i        (stage_imm_2),
        .decode_ready_i (decode_ready_i),
        .fetch_ready_o  (fetch_ready),
        .decode_valid_o (decode_valid_o),
        .instr_0_o      (instr_0_o),
        .instr_1_o      (instr_1_o),
        .instr_2_o      (instr_2_o),
        .pc_0_o         (pc_0_o),
        .pc_1_o         (pc_1_o),
        .pc_2_o         (pc_2_o),
        .imm_0_o        (imm_0_o),
        .imm_1_o        (imm_1_o),
        .imm_2_o        (imm_2_o),
        .buffer_empty_o (buffer_empty_o),
        .buffer_full_o  (buffer_full_o),
        .occupancy_o    (occupancy_o)
    );

endmodule

//--- logic/fetch_control.sv
`timescale 1ns/1ps

module fetch_control (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      bubble_i,
    // Buffer has room for a new group
    input  logic                      fetch_ready_i,
    // Start a memory read for the current group
    output logic                      issue_o,
    // Load the redirect target into the PC
    output logic                      load_pc_o,
    output fetch_pkg::fetch_state_t   state_o
);

    import fetch_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_nxt;
    logic         can_issue;

    // Room in the buffer and no stall
    assign can_issue = fetch_ready_i && !bubble_i;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_nxt = state_q;
        if (flush_i) begin
            // Any flush restarts through redirect
            state_nxt = FS_REDIRECT;
        end else begin
            case (state_q)
                FS_BOOT:     state_nxt = FS_RUN;
                FS_RUN: begin
                    if (!can_issue) begin
                        state_nxt = FS_HOLD;
                    end
                end
                // Wait for room and for the bubble to clear
                FS_HOLD: begin
                    if (can_issue) begin
                        state_nxt = FS_RUN;
                    end
                end
                // One dead cycle while the new PC settles
                FS_REDIRECT: state_nxt = FS_RUN;
                default:     state_nxt = FS_BOOT;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FS_BOOT;
        end else begin
            state_q <= state_nxt;
        end
    end

    // Issue only while running and never in a flush cycle
    assign issue_o   = (state_q == FS_RUN) && can_issue && !flush_i;
    // PC load pulses with the flush
    assign load_pc_o = flush_i;
    assign state_o   = state_q;

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////
    // Widths and sizes
    //////////////////////////////

    // Data word and address width
    localparam int XLEN = 32;
    // Instructions per fetch group
    localparam int FETCH_WIDTH = 3;
    // Instruction buffer entries
    localparam int BUFFER_DEPTH = 8;
    // PC step per group of 4-byte lanes
    localparam int GROUP_BYTES = FETCH_WIDTH * 4;
    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    //////////////////////////////
    // RV32I major opcodes
    //////////////////////////////

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Instruction or immediate word
    typedef logic [XLEN-1:0] word_t;
    // Byte address
    typedef logic [XLEN-1:0] pc_t;
    // One bit per lane with lane 0 in bit 0
    typedef logic [FETCH_WIDTH-1:0] lane_mask_t;
    // Occupancy 0 to BUFFER_DEPTH
    typedef logic [$clog2(BUFFER_DEPTH):0] occ_t;
    // Buffer index that wraps at depth
    typedef logic [$clog2(BUFFER_DEPTH)-1:0] ptr_t;

    // Fetch controller states
    typedef enum logic [1:0] {
        FS_BOOT,
        FS_RUN,
        FS_HOLD,
        FS_REDIRECT
    } fetch_state_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             issue_i,
    input  logic             flush_i,
    // Group base PC with lane k at base plus 4k
    input  fetch_pkg::pc_t   base_pc_i,
    input  fetch_pkg::word_t instruction_0_i,
    input  fetch_pkg::word_t instruction_1_i,
    input  fetch_pkg::word_t instruction_2_i,
    // One-cycle pulse per captured group
    output logic             group_valid_o,
    output fetch_pkg::word_t instr_0_o,
    output fetch_pkg::word_t instr_1_o,
    output fetch_pkg::word_t instr_2_o,
    output fetch_pkg::pc_t   pc_0_o,
    output fetch_pkg::pc_t   pc_1_o,
    output fetch_pkg::pc_t   pc_2_o,
    output fetch_pkg::word_t imm_0_o,
    output fetch_pkg::word_t imm_1_o,
    output fetch_pkg::word_t imm_2_o
);

    import fetch_pkg::*;

    word_t mem_word [FETCH_WIDTH];
    word_t instr_q  [FETCH_WIDTH];
    pc_t   pc_q     [FETCH_WIDTH];
    word_t imm_q    [FETCH_WIDTH];
    logic  valid_q;

    //////////////////////////////
    // Immediate decode
    //////////////////////////////

    // Sign-extended immediate by major opcode
    function automatic word_t imm_gen(input word_t ins);
        word_t imm;
        imm = '0;
        case (ins[6:0])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                imm = {{20{ins[31]}}, ins[31:20]};
            OPC_STORE:
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            // Branch offset with bit 0 always zero
            OPC_BRANCH:
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            // Upper 20 bits with low 12 cleared
            OPC_LUI, OPC_AUIPC:
                imm = {ins[31:12], 12'b0};
            OPC_JAL:
                imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:
                imm = '0;
        endcase
        return imm;
    endfunction

    assign mem_word[0] = instruction_0_i;
    assign mem_word[1] = instruction_1_i;
    assign mem_word[2] = instruction_2_i;

    // Group pulse that a flush drops
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i && !flush_i;
        end
    end

    // Payload capture on issue
    always_ff @(posedge clk) begin
        if (issue_i) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                instr_q[k] <= mem_word[k];
                pc_q[k]    <= base_pc_i + pc_t'(4 * k);
                imm_q[k]   <= imm_gen(mem_word[k]);
            end
        end
    end

    assign group_valid_o = valid_q;
    assign instr_0_o     = instr_q[0];
    assign instr_1_o     = instr_q[1];
    assign instr_2_o     = instr_q[2];
    assign pc_0_o        = pc_q[0];
    assign pc_1_o        = pc_q[1];
    assign pc_2_o        = pc_q[2];
    assign imm_0_o       = imm_q[0];
    assign imm_1_o       = imm_q[1];
    assign imm_2_o       = imm_q[2];

endmodule

//--- logic/instruction_buffer.sv
`timescale 1ns/1ps

module instruction_buffer (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Full group of three from the fetch stage
    input  logic                  write_i,
    input  fetch_pkg::word_t      instr_0_i,
    input  fetch_pkg::word_t      instr_1_i,
    input  fetch_pkg::word_t      instr_2_i,
    input  fetch_pkg::pc_t        pc_0_i,
    input  fetch_pkg::pc_t        pc_1_i,
    input  fetch_pkg::pc_t        pc_2_i,
    input  fetch_pkg::word_t      imm_0_i,
    input  fetch_pkg::word_t      imm_1_i,
    input  fetch_pkg::word_t      imm_2_i,
    input  fetch_pkg::lane_mask_t decode_ready_i,
    // Room for the group in flight plus one more
    output logic                  fetch_ready_o,
    output fetch_pkg::lane_mask_t decode_valid_o,
    output fetch_pkg::word_t      instr_0_o,
    output fetch_pkg::word_t      instr_1_o,
    output fetch_pkg::word_t      instr_2_o,
    output fetch_pkg::pc_t        pc_0_o,
    output fetch_pkg::pc_t        pc_1_o,
    output fetch_pkg::pc_t        pc_2_o,
    output fetch_pkg::word_t      imm_0_o,
    output fetch_pkg::word_t      imm_1_o,
    output fetch_pkg::word_t      imm_2_o,
    output logic                  buffer_empty_o,
    output logic                  buffer_full_o,
    output fetch_pkg::occ_t       occupancy_o
);

    import fetch_pkg::*;

    // Entry storage
    word_t instr_mem [BUFFER_DEPTH];
    pc_t   pc_mem    [BUFFER_DEPTH];
    word_t imm_mem   [BUFFER_DEPTH];

    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    occ_t       occ_q;
    occ_t       n_read;
    occ_t       n_write;
    ptr_t       wr_idx   [FETCH_WIDTH];
    ptr_t       rd_idx   [FETCH_WIDTH];
    word_t      in_instr [FETCH_WIDTH];
    pc_t        in_pc    [FETCH_WIDTH];
    word_t      in_imm   [FETCH_WIDTH];
    word_t      out_instr [FETCH_WIDTH];
    pc_t        out_pc    [FETCH_WIDTH];
    word_t      out_imm   [FETCH_WIDTH];
    lane_mask_t avail;
    lane_mask_t take;

    assign in_instr[0] = instr_0_i;
    assign in_instr[1] = instr_1_i;
    assign in_instr[2] = instr_2_i;
    assign in_pc[0]    = pc_0_i;
    assign in_pc[1]    = pc_1_i;
    assign in_pc[2]    = pc_2_i;
    assign in_imm[0]   = imm_0_i;
    assign in_imm[1]   = imm_1_i;
    assign in_imm[2]   = imm_2_i;

    //////////////////////////////
    // Read side
    //////////////////////////////

    always_comb begin
        n_read = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            // Pointers wrap with the index width
            wr_idx[k] = wr_ptr + ptr_t'(k);
            rd_idx[k] = rd_ptr + ptr_t'(k);
            // Oldest min(occupancy, 3) entries shown
            avail[k]  = occ_q > occ_t'(k);
            // Lane taken only if all lower lanes taken too
            if (k == 0) begin
                take[k] = avail[k] && decode_ready_i[k];
            end else begin
                take[k] = take[k-1] && avail[k] && decode_ready_i[k];
            end
            n_read = n_read + occ_t'(take[k]);
            // Idle lanes read as zero
            out_instr[k] = avail[k] ? instr_mem[rd_idx[k]] : '0;
            out_pc[k]    = avail[k] ? pc_mem[rd_idx[k]]    : '0;
            out_imm[k]   = avail[k] ? imm_mem[rd_idx[k]]   : '0;
        end
    end

    assign n_write = write_i ? occ_t'(FETCH_WIDTH) : '0;

    //////////////////////////////
    // Pointers and count
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ_q  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ_q  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_t'(n_write);
            rd_ptr <= rd_ptr + ptr_t'(n_read);
            // Write and read may land on the same edge
            occ_q  <= occ_q + n_write - n_read;
        end
    end

    // Group written in lane order at the tail
    always_ff @(posedge clk) begin
        if (write_i && !flush_i) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                instr_mem[wr_idx[k]] <= in_instr[k];
                pc_mem[wr_idx[k]]    <= in_pc[k];
                imm_mem[wr_idx[k]]   <= in_imm[k];
            end
        end
    end

    // Status
    assign fetch_ready_o  = occ_q <= occ_t'(BUFFER_DEPTH - 2 * FETCH_WIDTH);
    assign buffer_empty_o = occ_q == '0;
    assign buffer_full_o  = occ_q == occ_t'(BUFFER_DEPTH);
    assign occupancy_o    = occ_q;
    assign decode_valid_o = avail;

    assign instr_0_o = out_instr[0];
    assign instr_1_o = out_instr[1];
    assign instr_2_o = out_instr[2];
    assign pc_0_o    = out_pc[0];
    assign pc_1_o    = out_pc[1];
    assign pc_2_o    = out_pc[2];
    assign imm_0_o   = out_imm[0];
    assign imm_1_o   = out_imm[1];
    assign imm_2_o   = out_imm[2];

endmodule

//--- logic/pc_counter.sv
`timescale 1ns/1ps

module pc_counter (
    input  logic             clk,
    input  logic             rst_n_i,
    // Step one group forward
    input  logic             advance_i,
    // Redirect request and its target
    input  logic             load_i,
    input  fetch_pkg::pc_t   load_pc_i,
    // Base address of the current group
    output fetch_pkg::pc_t   pc_o
);

    import fetch_pkg::*;

    pc_t pc_q;
    pc_t pc_nxt;

    // Redirect wins over a normal step
    always_comb begin
        pc_nxt = pc_q;
        if (load_i) begin
            pc_nxt = load_pc_i;
        end else if (advance_i) begin
            pc_nxt = pc_q + pc_t'(GROUP_BYTES);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- verification/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb;

    import fetch_pkg::*;

    localparam int          CLK_PERIOD    = 100;
    localparam int          RESET_CYCLES  = 5;
    // Slack beyond the summed record lengths
    localparam int          MARGIN_CYCLES = 50;
    localparam logic [15:0] LFSR_SEED     = 16'd48827;
    localparam string       VECTOR_FILE   = "verification/fetch_vectors.txt";

    logic       clk;
    logic       rst_n;
    logic       flush;
    pc_t        redirect_pc;
    logic       bubble;
    lane_mask_t decode_ready;
    lane_mask_t decode_valid;
    pc_t        inst_addr_0, inst_addr_1, inst_addr_2;
    word_t      instruction_0, instruction_1, instruction_2;
    word_t      instr_0, instr_1, instr_2;
    pc_t        pc_0, pc_1, pc_2;
    word_t      imm_0, imm_1, imm_2;
    logic       buffer_empty;
    logic       buffer_full;
    occ_t       occupancy;

    // Memory model and test records
    word_t       mem [16];
    int          rec_test[$];
    int          rec_flush[$];
    pc_t         rec_pc[$];
    int          rec_bubble[$];
    int          rec_ready[$];
    int          rec_cycles[$];
    int          rec_expect[$];
    logic [15:0] lfsr_state;
    bit          load_ok;
    bit          vectors_ready = 1'b0;
    int          total_cycles;
    int          tests_run;
    int          err_base;
    int          acc_base;
    lane_mask_t  mask;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Combinational read that wraps every 64 bytes
    assign instruction_0 = mem[inst_addr_0[5:2]];
    assign instruction_1 = mem[inst_addr_1[5:2]];
    assign instruction_2 = mem[inst_addr_2[5:2]];

    fetch_buffer_top fetch_buffer_top_i (
        .clk (clk), .rst_n_i (rst_n),
        .inst_addr_0_o (inst_addr_0), .inst_addr_1_o (inst_addr_1), .inst_addr_2_o (inst_addr_2),
        .instruction_0_i (instruction_0), .instruction_1_i (instruction_1),
        .instruction_2_i (instruction_2),
        .flush_i (flush), .redirect_pc_i (redirect_pc), .bubble_i (bubble),
        .decode_ready_i (decode_ready), .decode_valid_o (decode_valid),
        .instr_0_o (instr_0), .instr_1_o (instr_1), .instr_2_o (instr_2),
        .pc_0_o (pc_0), .pc_1_o (pc_1), .pc_2_o (pc_2),
        .imm_0_o (imm_0), .imm_1_o (imm_1), .imm_2_o (imm_2),
        .buffer_empty_o (buffer_empty), .buffer_full_o (buffer_full), .occupancy_o (occupancy)
    );

    fetch_checker fetch_checker_i (
        .clk (clk), .rst_n_i (rst_n), .flush_i (flush), .redirect_pc_i (redirect_pc),
        .bubble_i (bubble), .decode_ready_i (decode_ready), .decode_valid_i (decode_valid),
        .instr_0_i (instr_0), .instr_1_i (instr_1), .instr_2_i (instr_2),
        .pc_0_i (pc_0), .pc_1_i (pc_1), .pc_2_i (pc_2),
        .imm_0_i (imm_0), .imm_1_i (imm_1), .imm_2_i (imm_2),
        .buffer_empty_i (buffer_empty), .buffer_full_i (buffer_full), .occupancy_i (occupancy)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per lane bit
    task automatic draw_ready_mask(output lane_mask_t m);
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            m[k] = lfsr_state[0];
        end
    endtask

    task automatic load_vectors(output bit ok);
        int    fd;
        int    n;
        int    idx;
        int    words;
        int    t, f, b, rd, c, e;
        pc_t   p;
        word_t w;
        string line;
        ok = 1'b0;
        words = 0;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VECTOR_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 0 && line.getc(0) == "m") begin
                    n = $sscanf(line, "m %d %h", idx, w);
                    if (n == 2) begin
                        mem[idx[3:0]] = w;
                        fetch_checker_i.store_word(idx, w);
                        words++;
                    end
                end else if (line.len() > 0 && line.getc(0) == "t") begin
                    n = $sscanf(line, "t %d %d %h %d %d %d %d", t, f, p, b, rd, c, e);
                    if (n == 7) begin
                        rec_test.push_back(t);
                        rec_flush.push_back(f);
                        rec_pc.push_back(p);
                        rec_bubble.push_back(b);
                        rec_ready.push_back(rd);
                        rec_cycles.push_back(c);
                        rec_expect.push_back(e);
                    end
                end
            end
            $fclose(fd);
            ok = (words == 16) && (rec_test.size() > 0);
            if (!ok)
                $display("vector file holds %0d memory words and %0d records, not usable",
                    words, rec_test.size());
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        rst_n        = 1'b0;
        flush        = 1'b0;
        redirect_pc  = '0;
        bubble       = 1'b0;
        decode_ready = '0;
        lfsr_state   = LFSR_SEED;
        tests_run    = 0;
        total_cycles = 0;
        load_vectors(load_ok);
        if (!load_ok) begin
            $display("=== FAIL ===");
        end else begin
            foreach (rec_cycles[r])
                total_cycles += rec_cycles[r];
            vectors_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            @(posedge clk);
            for (int r = 0; r < rec_test.size(); r++) begin
                // Counts restart on the first record of a test
                if (r == 0 || rec_test[r] != rec_test[r-1]) begin
                    err_base = fetch_checker_i.error_count;
                    acc_base = fetch_checker_i.accept_count;
                end
                fetch_checker_i.begin_record();
                for (int i = 0; i < rec_cycles[r]; i++) begin
                    // Flush pulses in the first cycle only
                    flush       <= (i == 0) && (rec_flush[r] != 0);
                    redirect_pc <= rec_pc[r];
                    bubble      <= rec_bubble[r] != 0;
                    if (rec_ready[r] > 7)
                        draw_ready_mask(mask);
                    else
                        mask = lane_mask_t'(rec_ready[r]);
                    decode_ready <= mask;
                    @(posedge clk);
                end
                fetch_checker_i.end_record(rec_expect[r]);
                if (r == rec_test.size() - 1 || rec_test[r+1] != rec_test[r]) begin
                    tests_run++;
                    $display("test %0d finished: %0d instructions checked, %0d errors",
                        rec_test[r], fetch_checker_i.accept_count - acc_base,
                        fetch_checker_i.error_count - err_base);
                end
            end
            $display("%0d tests, %0d instructions checked, %0d errors", tests_run,
                fetch_checker_i.accept_count, fetch_checker_i.error_count);
            if (fetch_checker_i.error_count == 0)
                $display("=== PASS ===");
            else
                $display("=== FAIL ===");
        end
        $finish;
    end

    // Ends a stuck run
    initial begin : watchdog
        wait (vectors_ready);
        #(CLK_PERIOD * (RESET_CYCLES + 1 + total_cycles + MARGIN_CYCLES));
        $display("watchdog expired, the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verification/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  fetch_pkg::pc_t        redirect_pc_i,
    input  logic                  bubble_i,
    input  fetch_pkg::lane_mask_t decode_ready_i,
    input  fetch_pkg::lane_mask_t decode_valid_i,
    input  fetch_pkg::word_t      instr_0_i,
    input  fetch_pkg::word_t      instr_1_i,
    input  fetch_pkg::word_t      instr_2_i,
    input  fetch_pkg::pc_t        pc_0_i,
    input  fetch_pkg::pc_t        pc_1_i,
    input  fetch_pkg::pc_t        pc_2_i,
    input  fetch_pkg::word_t      imm_0_i,
    input  fetch_pkg::word_t      imm_1_i,
    input  fetch_pkg::word_t      imm_2_i,
    input  logic                  buffer_empty_i,
    input  logic                  buffer_full_i,
    input  fetch_pkg::occ_t       occupancy_i
);

    import fetch_pkg::*;

    // Own copy of the 64-byte memory image
    word_t      image [16];
    word_t      lane_instr [FETCH_WIDTH];
    pc_t        lane_pc    [FETCH_WIDTH];
    word_t      lane_imm   [FETCH_WIDTH];
    // Next PC decode should see
    pc_t        exp_pc;
    int         error_count  = 0;
    int         accept_count = 0;
    int         rec_accept   = 0;
    bit         full_seen;
    bit         prev_flush;
    bit         prev_empty;
    occ_t       last_occ;
    // Bubble in the last two cycles with the older one in bit 1
    logic [1:0] bubble_hist;

    assign lane_instr[0] = instr_0_i;
    assign lane_instr[1] = instr_1_i;
    assign lane_instr[2] = instr_2_i;
    assign lane_pc[0]    = pc_0_i;
    assign lane_pc[1]    = pc_1_i;
    assign lane_pc[2]    = pc_2_i;
    assign lane_imm[0]   = imm_0_i;
    assign lane_imm[1]   = imm_1_i;
    assign lane_imm[2]   = imm_2_i;

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    // Immediate by format with the sign from bit 31 by arithmetic shift
    function automatic word_t expected_imm(input word_t w);
        word_t imm;
        case (w[6:0])
            7'b0010011, 7'b0000011, 7'b1100111:
                imm = word_t'($signed(w) >>> 20);
            7'b0100011:
                imm = word_t'($signed({w[31:25], w[11:7], 20'b0}) >>> 20);
            7'b1100011:
                imm = word_t'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0}) >>> 19);
            7'b0110111, 7'b0010111:
                imm = w & 32'hffff_f000;
            7'b1101111:
                imm = word_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0}) >>> 11);
            default:
                imm = '0;
        endcase
        return imm;
    endfunction

    // Oldest min(occupancy, 3) lanes shown
    function automatic lane_mask_t visible_mask(input occ_t occ);
        if (occ >= 3) return 3'b111;
        if (occ == 2) return 3'b011;
        if (occ == 1) return 3'b001;
        return 3'b000;
    endfunction

    task automatic flag_error(input string msg);
        $display("error %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic store_word(input int idx, input word_t w);
        image[idx[3:0]] = w;
    endtask

    task automatic verify_status();
        if (occupancy_i > occ_t'(BUFFER_DEPTH))
            flag_error($sformatf("occupancy_o %0d above depth", occupancy_i));
        if (buffer_empty_i !== (occupancy_i == 0))
            flag_error($sformatf("buffer_empty_o %b at occupancy %0d", buffer_empty_i, occupancy_i));
        if (buffer_full_i !== (occupancy_i == BUFFER_DEPTH))
            flag_error($sformatf("buffer_full_o %b at occupancy %0d", buffer_full_i, occupancy_i));
        if (decode_valid_i !== visible_mask(occupancy_i))
            flag_error($sformatf("decode_valid_o %b at occupancy %0d", decode_valid_i,
                occupancy_i));
        if (occupancy_i == BUFFER_DEPTH && buffer_full_i)
            full_seen = 1'b1;
    endtask

    // Thermometer take where each taken lane is next in program order
    task automatic check_lanes();
        bit    chain;
        word_t w;
        chain = 1'b1;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            chain = chain && decode_valid_i[k] && decode_ready_i[k];
            if (chain) begin
                w = image[exp_pc[5:2]];
                if (lane_pc[k] !== exp_pc) begin
                    flag_error($sformatf("lane %0d pc %h, expected %h", k, lane_pc[k], exp_pc));
                    // Follow the DUT stream after a slip
                    exp_pc = lane_pc[k];
                    w = image[exp_pc[5:2]];
                end
                if (lane_instr[k] !== w)
                    flag_error($sformatf("lane %0d instr %h, expected %h", k, lane_instr[k], w));
                if (lane_imm[k] !== expected_imm(w))
                    flag_error($sformatf("lane %0d imm %h, expected %h", k, lane_imm[k],
                        expected_imm(w)));
                exp_pc = exp_pc + 4;
                accept_count++;
                rec_accept++;
            end
        end
    endtask

    //////////////////////////////
    // Record hooks
    //////////////////////////////

    task automatic begin_record();
        rec_accept = 0;
        full_seen  = 1'b0;
    endtask

    task automatic end_record(input int expect_bits);
        if (expect_bits[0] && !full_seen)
            flag_error("occupancy_o never reached 8 with buffer_full_o high");
        if (expect_bits[1] && (!prev_empty || last_occ != 0))
            flag_error($sformatf("buffer not drained, occupancy %0d", last_occ));
        if (expect_bits[2] && rec_accept == 0)
            flag_error("decode took no instruction");
    endtask

    // Mid-cycle sampling while inputs and outputs are settled
    always @(negedge clk) begin
        if (!rst_n_i) begin
            if (decode_valid_i !== '0 || occupancy_i !== '0 || buffer_empty_i !== 1'b1 ||
                buffer_full_i !== 1'b0)
                flag_error("outputs not at reset values");
            exp_pc      = RESET_PC;
            prev_flush  = 1'b0;
            prev_empty  = 1'b1;
            last_occ    = '0;
            bubble_hist = '0;
        end else begin
            verify_status();
            check_lanes();
            if (prev_flush && !buffer_empty_i)
                flag_error("buffer_empty_o low in the cycle after a flush");
            // Two bubble cycles leave no group in flight
            if (bubble_hist == 2'b11 && prev_empty && !buffer_empty_i)
                flag_error("new instructions arrived while bubble_i held fetch");
            if (flush_i)
                exp_pc = redirect_pc_i;
            prev_flush  = flush_i;
            prev_empty  = buffer_empty_i;
            last_occ    = occupancy_i;
            bubble_hist = {bubble_hist[0], bubble_i};
        end
    end

endmodule

//--- verification/fetch_vectors.txt
# m <word index> <instruction word>, byte address is 4 * index
# t <test> <flush> <redirect_pc> <bubble> <ready> <cycles> <expect>
# ready 0 to 7 is a fixed lane mask, 8 draws the mask from the LFSR
# expect bit 0 full seen, bit 1 empty at end, bit 2 instructions taken
m 0 00500093
m 1 fff00113
m 2 0000a183
m 3 00312223
m 4 fe208ee3
m 5 123450b7
m 6 fffff197
m 7 008000ef
m 8 00008067
m 9 002081b3
m 10 80000113
m 11 fe112e23
m 12 7e000fe3
m 13 800000ef
m 14 0000000f
m 15 ffc4a303
t 1 0 00000000 0 7 40 4
t 2 0 00000000 0 8 60 4
t 3 0 00000000 1 7 20 2
t 3 0 00000000 0 7 20 4
t 4 1 00000024 0 7 30 4
t 4 1 00000038 0 8 30 4
t 5 1 00000010 0 1 8 0
t 5 0 00000000 0 0 20 1
t 5 0 00000000 1 7 10 2
